//--- include/lc3b_settings.svh
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// first fetch address after reset
`define LC3B_RESET_PC 16'h0000

// nzp after reset, zero set
`define LC3B_CC_RESET 3'b010

`endif

//--- source/lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;      // {n, z, p}

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,              // also JSRR
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,              // also RET
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

endpackage : lc3b_types

//--- source/lc3b_control_types.sv
package lc3b_control;

    // value 0 of every select is the no-op choice
    typedef enum logic [2:0] {
        lc3b_alu_op_pass = 3'd0,
        lc3b_alu_op_add  = 3'd1,
        lc3b_alu_op_and  = 3'd2,
        lc3b_alu_op_not  = 3'd3,
        lc3b_alu_op_sll  = 3'd4,
        lc3b_alu_op_srl  = 3'd5,
        lc3b_alu_op_sra  = 3'd6
    } lc3b_alu_op;

    typedef enum logic [2:0] {
        lc3b_alu_mux_sel_sr2       = 3'd0,
        lc3b_alu_mux_sel_imm5      = 3'd1,
        lc3b_alu_mux_sel_imm4      = 3'd2,
        lc3b_alu_mux_sel_offset6_b = 3'd3,
        lc3b_alu_mux_sel_offset6_w = 3'd4
    } lc3b_alu_mux_sel;

    typedef enum logic [1:0] {
        lc3b_pc_mux_sel_pc_plus2 = 2'd0,
        lc3b_pc_mux_sel_pcn      = 2'd1,
        lc3b_pc_mux_sel_alu      = 2'd2
    } lc3b_pc_mux_sel;

    typedef enum logic {
        lc3b_pc_adder_mux_sel_offset9  = 1'b0,
        lc3b_pc_adder_mux_sel_offset11 = 1'b1
    } lc3b_pc_adder_mux_sel;

    typedef enum logic [1:0] {
        lc3b_regfile_data_mux_sel_alu = 2'd0,
        lc3b_regfile_data_mux_sel_pcn = 2'd1,
        lc3b_regfile_data_mux_sel_mdr = 2'd2,
        lc3b_regfile_data_mux_sel_pc  = 2'd3
    } lc3b_regfile_data_mux_sel;

    typedef enum logic [1:0] {
        lc3b_cc_gen_mux_sel_alu = 2'd0,
        lc3b_cc_gen_mux_sel_pcn = 2'd1,
        lc3b_cc_gen_mux_sel_mdr = 2'd2
    } lc3b_cc_gen_mux_sel;

    typedef struct packed {
        logic                     conditional_branch;
        lc3b_pc_mux_sel           pc_mux_sel;
        lc3b_types::lc3b_reg      regfile_sr1;
        lc3b_types::lc3b_reg      regfile_sr2;      // store source for STR/STB
        lc3b_pc_adder_mux_sel     pc_adder_mux_sel;
        lc3b_alu_mux_sel          alu_mux_sel;
        lc3b_alu_op               alu_op;
        logic                     cc_load;
        lc3b_cc_gen_mux_sel       cc_gen_mux_sel;
        logic                     data_memory_access;
        logic                     data_memory_write_enable;
        logic                     data_memory_word_align;
        lc3b_regfile_data_mux_sel regfile_data_mux_sel;
        lc3b_types::lc3b_reg      regfile_dest;
        logic                     regfile_load;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_types::lc3b_word alu_out;
        lc3b_types::lc3b_word pcn;          // pc adder sum
        lc3b_types::lc3b_word pc_plus2;
    } lc3b_exec_result;

endpackage : lc3b_control

//--- source/control_rom.sv
`timescale 1ns/10ps

module control_rom (
    input  lc3b_types::lc3b_word          ir_in,
    output lc3b_control::lc3b_control_word control_out
);
    import lc3b_types::*;
    import lc3b_control::*;

    lc3b_opcode opcode;
    lc3b_reg    dest;
    lc3b_reg    sr1;
    lc3b_reg    sr2;

    assign opcode = lc3b_opcode'(ir_in[15:12]);
    assign dest   = ir_in[11:9];
    assign sr1    = ir_in[8:6];
    assign sr2    = ir_in[2:0];

    always_comb begin
        // fetch
        control_out.conditional_branch = 1'b0;
        control_out.pc_mux_sel = lc3b_pc_mux_sel_pc_plus2;

        // register reads
        control_out.regfile_sr1 = '0;
        control_out.regfile_sr2 = '0;

        // execute
        control_out.pc_adder_mux_sel = lc3b_pc_adder_mux_sel_offset9;
        control_out.alu_mux_sel = lc3b_alu_mux_sel_sr2;
        control_out.alu_op = lc3b_alu_op_pass;

        // memory and cc
        control_out.cc_load = 1'b0;
        control_out.cc_gen_mux_sel = lc3b_cc_gen_mux_sel_alu;
        control_out.data_memory_access = 1'b0;
        control_out.data_memory_write_enable = 1'b0;
        control_out.data_memory_word_align = 1'b0;

        // write back
        control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_alu;
        control_out.regfile_dest = '0;
        control_out.regfile_load = 1'b0;

        case (opcode)
            op_add, op_and: begin
                control_out.regfile_sr1 = sr1;
                control_out.regfile_sr2 = sr2;
                if (ir_in[5])
                    control_out.alu_mux_sel = lc3b_alu_mux_sel_imm5;
                if (opcode == op_add)
                    control_out.alu_op = lc3b_alu_op_add;
                else
                    control_out.alu_op = lc3b_alu_op_and;
                control_out.cc_load = 1'b1;
                control_out.regfile_dest = dest;
                control_out.regfile_load = 1'b1;
            end

            op_not: begin
                control_out.regfile_sr1 = sr1;
                control_out.alu_op = lc3b_alu_op_not;
                control_out.cc_load = 1'b1;
                control_out.regfile_dest = dest;
                control_out.regfile_load = 1'b1;
            end

            op_shf: begin
                control_out.regfile_sr1 = sr1;
                control_out.alu_mux_sel = lc3b_alu_mux_sel_imm4;
                if (!ir_in[4])
                    control_out.alu_op = lc3b_alu_op_sll;
                else if (!ir_in[5])
                    control_out.alu_op = lc3b_alu_op_srl;
                else
                    control_out.alu_op = lc3b_alu_op_sra;
                control_out.cc_load = 1'b1;
                control_out.regfile_dest = dest;
                control_out.regfile_load = 1'b1;
            end

            op_lea: begin
                control_out.cc_load = 1'b1;
                control_out.cc_gen_mux_sel = lc3b_cc_gen_mux_sel_pcn;   // cc from address
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_pcn;
                control_out.regfile_dest = dest;
                control_out.regfile_load = 1'b1;
            end

            op_ldr, op_ldb: begin
                control_out.regfile_sr1 = sr1;
                control_out.alu_op = lc3b_alu_op_add;
                if (opcode == op_ldr) begin
                    control_out.alu_mux_sel = lc3b_alu_mux_sel_offset6_w;
                    control_out.data_memory_word_align = 1'b1;
                end else begin
                    control_out.alu_mux_sel = lc3b_alu_mux_sel_offset6_b;
                end
                control_out.cc_load = 1'b1;
                control_out.cc_gen_mux_sel = lc3b_cc_gen_mux_sel_mdr;
                control_out.data_memory_access = 1'b1;
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_mdr;
                control_out.regfile_dest = dest;
                control_out.regfile_load = 1'b1;
            end

            op_str, op_stb: begin
                control_out.regfile_sr1 = sr1;
                control_out.regfile_sr2 = dest;     // store source sits in [11:9]
                control_out.alu_op = lc3b_alu_op_add;
                if (opcode == op_str) begin
                    control_out.alu_mux_sel = lc3b_alu_mux_sel_offset6_w;
                    control_out.data_memory_word_align = 1'b1;
                end else begin
                    control_out.alu_mux_sel = lc3b_alu_mux_sel_offset6_b;
                end
                control_out.data_memory_access = 1'b1;
                control_out.data_memory_write_enable = 1'b1;
            end

            op_br: begin
                control_out.conditional_branch = 1'b1;
                control_out.pc_mux_sel = lc3b_pc_mux_sel_pcn;
            end

            op_jmp: begin
                control_out.regfile_sr1 = sr1;      // R7 for RET
                control_out.pc_mux_sel = lc3b_pc_mux_sel_alu;
            end

            op_jsr: begin
                control_out.regfile_sr1 = sr1;
                if (ir_in[11])
                    control_out.pc_mux_sel = lc3b_pc_mux_sel_pcn;  // JSR
                else
                    control_out.pc_mux_sel = lc3b_pc_mux_sel_alu;  // JSRR
                control_out.pc_adder_mux_sel = lc3b_pc_adder_mux_sel_offset11;
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_pc;
                control_out.regfile_dest = 3'd7;
                control_out.regfile_load = 1'b1;
            end

            // rti, ldi, sti, trap: plain pc+2
            default: begin
                control_out = '0;
            end
        endcase
    end

    // loads and stores never share a cycle
    always_comb begin
        assert (!(control_out.regfile_load && control_out.data_memory_write_enable))
            else $error("control_rom: register load during store, opcode %b", ir_in[15:12]);
    end

endmodule : control_rom

//--- source/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_reg  sr1,
    input  lc3b_types::lc3b_reg  sr2,
    input  lc3b_types::lc3b_word in,
    output lc3b_types::lc3b_word sr1_out,
    output lc3b_types::lc3b_word sr2_out
);
    import lc3b_types::*;

    lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // no bypass, old value during a write
    assign sr1_out = regs[sr1];
    assign sr2_out = regs[sr2];

    dest_known: assert property (@(posedge clk) disable iff (reset)
        load |-> !$isunknown(dest))
        else $error("regfile: write with unknown dest");

endmodule : regfile

//--- source/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input  logic                           reset,
    input  lc3b_control::lc3b_control_word ctrl,
    input  lc3b_types::lc3b_word           ir,
    input  lc3b_types::lc3b_word           pc,
    input  lc3b_types::lc3b_word           sr1_data,
    input  lc3b_types::lc3b_word           sr2_data,
    output lc3b_control::lc3b_exec_result  result,
    output lc3b_types::lc3b_word           mem_addr,
    output lc3b_types::lc3b_word           mem_wdata,
    output logic                           mem_read,
    output logic                           mem_write,
    output logic [1:0]                     mem_byte_enable
);
    import lc3b_types::*;
    import lc3b_control::*;

    lc3b_word alu_b;
    lc3b_word alu_out;
    lc3b_word pc_plus2;
    lc3b_word pc_offset;
    lc3b_word pcn;

    always_comb begin
        case (ctrl.alu_mux_sel)
            lc3b_alu_mux_sel_imm5:      alu_b = {{11{ir[4]}}, ir[4:0]};
            lc3b_alu_mux_sel_imm4:      alu_b = {12'b0, ir[3:0]};
            lc3b_alu_mux_sel_offset6_b: alu_b = {{10{ir[5]}}, ir[5:0]};
            lc3b_alu_mux_sel_offset6_w: alu_b = {{9{ir[5]}}, ir[5:0], 1'b0};
            default:                    alu_b = sr2_data;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            lc3b_alu_op_add: alu_out = sr1_data + alu_b;
            lc3b_alu_op_and: alu_out = sr1_data & alu_b;
            lc3b_alu_op_not: alu_out = ~sr1_data;
            lc3b_alu_op_sll: alu_out = sr1_data << alu_b[3:0];
            lc3b_alu_op_srl: alu_out = sr1_data >> alu_b[3:0];
            lc3b_alu_op_sra: alu_out = lc3b_word'($signed(sr1_data) >>> alu_b[3:0]);
            default:         alu_out = sr1_data;    // pass for jmp/jsrr target
        endcase
    end

    // pc adder adds word offsets to pc+2
    assign pc_plus2 = pc + 16'd2;
    assign pc_offset = (ctrl.pc_adder_mux_sel == lc3b_pc_adder_mux_sel_offset11)
                     ? {{4{ir[10]}}, ir[10:0], 1'b0}
                     : {{6{ir[8]}}, ir[8:0], 1'b0};
    assign pcn = pc_plus2 + pc_offset;

    assign result = '{alu_out: alu_out, pcn: pcn, pc_plus2: pc_plus2};

    // data memory side
    assign mem_addr = ctrl.data_memory_word_align ? {alu_out[15:1], 1'b0} : alu_out;
    assign mem_wdata = ctrl.data_memory_word_align ? sr2_data
                                                   : {sr2_data[7:0], sr2_data[7:0]};
    assign mem_byte_enable = ctrl.data_memory_word_align ? 2'b11
                           : (alu_out[0] ? 2'b10 : 2'b01);     // lane by addr bit 0
    assign mem_read  = !reset && ctrl.data_memory_access && !ctrl.data_memory_write_enable;
    assign mem_write = !reset && ctrl.data_memory_access && ctrl.data_memory_write_enable;

    // a write enable without an access would be dropped
    always_comb begin
        assert (!ctrl.data_memory_write_enable || ctrl.data_memory_access)
            else $error("execute_unit: write enable without memory access");
    end

endmodule : execute_unit

//--- source/result_unit.sv
`timescale 1ns/10ps
`include "lc3b_settings.svh"

module result_unit (
    input  logic                           clk,
    input  logic                           reset,
    input  lc3b_control::lc3b_control_word ctrl,
    input  lc3b_types::lc3b_word           ir,
    input  lc3b_control::lc3b_exec_result  exec,
    input  lc3b_types::lc3b_word           mem_rdata,
    output lc3b_types::lc3b_word           pc,
    output lc3b_types::lc3b_word           rf_data
);
    import lc3b_types::*;
    import lc3b_control::*;

    lc3b_word load_data;
    lc3b_word cc_src;
    lc3b_nzp  cc_gen;
    lc3b_nzp  cc;
    logic     branch_taken;
    lc3b_word pc_next;

    always_comb begin
        if (ctrl.data_memory_word_align)
            load_data = mem_rdata;
        else if (exec.alu_out[0])
            load_data = {{8{mem_rdata[15]}}, mem_rdata[15:8]};  // odd byte
        else
            load_data = {{8{mem_rdata[7]}}, mem_rdata[7:0]};
    end

    always_comb begin
        case (ctrl.regfile_data_mux_sel)
            lc3b_regfile_data_mux_sel_pcn: rf_data = exec.pcn;
            lc3b_regfile_data_mux_sel_mdr: rf_data = load_data;
            lc3b_regfile_data_mux_sel_pc:  rf_data = exec.pc_plus2;  // link for jsr
            default:                       rf_data = exec.alu_out;
        endcase
    end

    always_comb begin
        case (ctrl.cc_gen_mux_sel)
            lc3b_cc_gen_mux_sel_pcn: cc_src = exec.pcn;
            lc3b_cc_gen_mux_sel_mdr: cc_src = load_data;
            default:                 cc_src = exec.alu_out;
        endcase
    end

    assign cc_gen = {cc_src[15], cc_src == 16'h0000, !cc_src[15] && cc_src != 16'h0000};

    assign branch_taken = ctrl.conditional_branch && |(ir[11:9] & cc);

    always_comb begin
        case (ctrl.pc_mux_sel)
            lc3b_pc_mux_sel_alu: pc_next = exec.alu_out;
            lc3b_pc_mux_sel_pcn: pc_next = (!ctrl.conditional_branch || branch_taken)
                                         ? exec.pcn : exec.pc_plus2;
            default:             pc_next = exec.pc_plus2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `LC3B_RESET_PC;
            cc <= `LC3B_CC_RESET;
        end else begin
            pc <= pc_next;
            if (ctrl.cc_load)
                cc <= cc_gen;
        end
    end

    pc_even: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
        else $error("result_unit: odd pc %h", pc);

endmodule : result_unit

//--- source/lc3b_core.sv
`timescale 1ns/10ps

module lc3b_core (
    input  logic                 clk,
    input  logic                 reset,
    output lc3b_types::lc3b_word inst_addr,
    input  lc3b_types::lc3b_word inst_data,
    output lc3b_types::lc3b_word mem_addr,
    output lc3b_types::lc3b_word mem_wdata,
    input  lc3b_types::lc3b_word mem_rdata,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic [1:0]           mem_byte_enable
);
    import lc3b_types::*;
    import lc3b_control::*;

    lc3b_control_word ctrl;
    lc3b_word         sr1_data;
    lc3b_word         sr2_data;
    lc3b_word         rf_data;
    lc3b_exec_result  exec_result;

    control_rom u_control_rom (
        .ir_in       (inst_data),
        .control_out (ctrl)
    );

    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .load    (ctrl.regfile_load),
        .dest    (ctrl.regfile_dest),
        .sr1     (ctrl.regfile_sr1),
        .sr2     (ctrl.regfile_sr2),
        .in      (rf_data),
        .sr1_out (sr1_data),
        .sr2_out (sr2_data)
    );

    execute_unit u_execute_unit (
        .reset           (reset),
        .ctrl            (ctrl),
        .ir              (inst_data),
        .pc              (inst_addr),       // fetch address is the pc
        .sr1_data        (sr1_data),
        .sr2_data        (sr2_data),
        .result          (exec_result),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable)
    );

    result_unit u_result_unit (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .ir        (inst_data),
        .exec      (exec_result),
        .mem_rdata (mem_rdata),
        .pc        (inst_addr),
        .rf_data   (rf_data)
    );

endmodule : lc3b_core

//--- tests/lc3b_core_tb.sv
`timescale 1ns/10ps
`include "lc3b_settings.svh"

module lc3b_core_tb;
    import lc3b_types::*;

    localparam lc3b_word HALT = 16'h0FFF;   // brnzp #-1 loops on itself

    logic       clk;
    logic       reset;
    lc3b_word   inst_addr;
    lc3b_word   inst_data;
    lc3b_word   mem_addr;
    lc3b_word   mem_wdata;
    lc3b_word   mem_rdata;
    logic       mem_read;
    logic       mem_write;
    logic [1:0] mem_byte_enable;

    lc3b_word   imem [256];
    logic [7:0] dmem [1024];              // little endian bytes
    lc3b_word   pc_trace [$];
    integer     seed;
    int         slot;
    int         checks;
    int         errors;

    lc3b_core u_lc3b_core (
        .clk             (clk),
        .reset           (reset),
        .inst_addr       (inst_addr),
        .inst_data       (inst_data),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable)
    );

    assign inst_data = imem[inst_addr[8:1]];
    assign mem_rdata = {dmem[{mem_addr[9:1], 1'b1}], dmem[{mem_addr[9:1], 1'b0}]};

    always #20 clk = ~clk;

    function automatic logic [7:0] fill_byte(input logic [9:0] a);
        return a[7:0] ^ {6'b101101, a[9:8]};
    endfunction

    function automatic lc3b_word encode(input lc3b_opcode op, input lc3b_reg a,
                                        input lc3b_reg b, input logic [5:0] low);
        return {op, a, b, low};
    endfunction

    function automatic lc3b_word encode9(input lc3b_opcode op, input lc3b_reg a,
                                         input logic [8:0] off9);
        return {op, a, off9};
    endfunction

    function automatic lc3b_nzp nzp_of(input lc3b_word w);
        if ($signed(w) < 0)
            return 3'b100;
        else if (w == 16'h0000)
            return 3'b010;
        else
            return 3'b001;
    endfunction

    function automatic logic is_noop(input lc3b_word w);
        return lc3b_opcode'(w[15:12]) inside {op_rti, op_ldi, op_sti, op_trap};
    endfunction

    function automatic lc3b_word read_word(input int addr);
        return {dmem[10'(addr + 1)], dmem[10'(addr)]};
    endfunction

    task automatic compare(input string what, input lc3b_word got, input lc3b_word want);
        checks++;
        assert (got === want)
            else begin
                errors++;
                $display("error at %0t: %s, got %h, expected %h", $time, what, got, want);
            end
    endtask

    task automatic emit(input lc3b_word w);
        imem[8'(slot)] = w;
        slot++;
    endtask

    task automatic place(input int addr);
        slot = addr / 2;
    endtask

    task automatic write_word(input int addr, input lc3b_word w);
        dmem[10'(addr)] = w[7:0];
        dmem[10'(addr + 1)] = w[15:8];
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 256; i++)
            imem[8'(i)] = {7'b0000000, 9'(i)};      // br with empty mask is never taken
        for (int i = 0; i < 1024; i++)
            dmem[10'(i)] = fill_byte(10'(i));
        slot = 0;
    endtask

    task automatic hold_reset();
        @(posedge clk);
        #2;
        reset = 1'b1;
    endtask

    task automatic release_reset();
        repeat (3) begin
            @(posedge clk);
            #2;
            checks++;
            assert (!mem_read && !mem_write)
                else begin
                    errors++;
                    $display("error at %0t: memory strobe high during reset", $time);
                end
        end
        compare("pc during reset", inst_addr, `LC3B_RESET_PC);
        reset = 1'b0;
    endtask

    // steps the core until it sits on a halt loop
    task automatic run_to_halt();
        int         cycles;
        logic       was_noop;
        logic       want_read;
        logic       want_write;
        logic       wr;
        lc3b_word   wr_addr;
        lc3b_word   wr_data;
        logic [1:0] wr_be;
        lc3b_word   prev_addr;
        cycles = 0;
        pc_trace.delete();
        while (inst_data !== HALT && cycles < 200) begin
            @(negedge clk);                     // mid cycle
            pc_trace.push_back(inst_addr);
            prev_addr = inst_addr;
            was_noop = is_noop(inst_data);
            want_read = lc3b_opcode'(inst_data[15:12]) inside {op_ldr, op_ldb};
            want_write = lc3b_opcode'(inst_data[15:12]) inside {op_str, op_stb};
            wr = mem_write;
            wr_addr = mem_addr;
            wr_data = mem_wdata;
            wr_be = mem_byte_enable;
            checks++;
            assert (mem_read === want_read && mem_write === want_write)
                else begin
                    errors++;
                    $display("error at %0t: strobes read %b write %b at %h, expected %b %b",
                             $time, mem_read, mem_write, prev_addr, want_read, want_write);
                end
            @(posedge clk);
            // data memory takes the write at the edge
            if (wr && wr_be[0])
                dmem[{wr_addr[9:1], 1'b0}] = wr_data[7:0];
            if (wr && wr_be[1])
                dmem[{wr_addr[9:1], 1'b1}] = wr_data[15:8];
            #2;
            cycles++;
            if (was_noop)
                compare("pc after no-op", inst_addr, prev_addr + 16'd2);
        end
        pc_trace.push_back(inst_addr);
        if (inst_data !== HALT) begin
            errors++;
            $display("timeout: core reached no halt loop in 200 cycles, pc %h", inst_addr);
        end
    endtask

    task automatic test_alu();
        lc3b_word   a;
        lc3b_word   b;
        logic [4:0] imm_a;
        logic [4:0] imm_b;
        for (int n = 0; n < 3; n++) begin
            a = 16'($random(seed));
            b = 16'($random(seed));
            imm_a = 5'($random(seed));
            imm_b = 5'($random(seed));
            hold_reset();
            clear_memories();
            write_word(0, a);
            write_word(2, b);
            emit(encode(op_ldr, 3'd1, 3'd0, 6'd0));
            emit(encode(op_ldr, 3'd2, 3'd0, 6'd1));
            emit(encode(op_add, 3'd3, 3'd1, 6'd2));     // register form with sr2 = r2
            emit(encode(op_str, 3'd3, 3'd0, 6'd16));
            emit(encode(op_add, 3'd3, 3'd1, {1'b1, imm_a}));
            emit(encode(op_str, 3'd3, 3'd0, 6'd17));
            emit(encode(op_and, 3'd3, 3'd1, 6'd2));
            emit(encode(op_str, 3'd3, 3'd0, 6'd18));
            emit(encode(op_and, 3'd3, 3'd1, {1'b1, imm_b}));
            emit(encode(op_str, 3'd3, 3'd0, 6'd19));
            emit(encode(op_not, 3'd3, 3'd1, 6'h3f));
            emit(encode(op_str, 3'd3, 3'd0, 6'd20));
            emit(HALT);
            release_reset();
            run_to_halt();
            compare("add register", read_word(32), a + b);
            compare("add immediate", read_word(34), a + {{11{imm_a[4]}}, imm_a});
            compare("and register", read_word(36), a & b);
            compare("and immediate", read_word(38), a & {{11{imm_b[4]}}, imm_b});
            compare("not", read_word(40), ~a);
        end
    endtask

    task automatic test_shift();
        lc3b_word   v;
        lc3b_word   want;
        logic [3:0] amts [4];
        logic [1:0] kinds [3];
        amts = '{4'd0, 4'd1, 4'd7, 4'd15};
        kinds = '{2'b00, 2'b01, 2'b11};           // sll, srl, sra in ir[5:4]
        for (int n = 0; n < 2; n++) begin
            v = 16'($random(seed));
            v[15] = (n == 0);                      // one negative pass
            hold_reset();
            clear_memories();
            write_word(0, v);
            emit(encode(op_ldr, 3'd1, 3'd0, 6'd0));
            for (int k = 0; k < 4; k++) begin
                for (int s = 0; s < 3; s++) begin
                    emit(encode(op_shf, 3'd3, 3'd1, {kinds[s], amts[k]}));
                    emit(encode(op_str, 3'd3, 3'd0, 6'(16 + 3 * k + s)));
                end
            end
            emit(HALT);
            release_reset();
            run_to_halt();
            for (int k = 0; k < 4; k++) begin
                for (int s = 0; s < 3; s++) begin
                    if (s == 0)
                        want = v << amts[k];
                    else if (s == 1)
                        want = v >> amts[k];
                    else
                        want = (v >> amts[k]) | (v[15] ? ~(16'hffff >> amts[k]) : 16'h0000);
                    compare("shift", read_word(2 * (16 + 3 * k + s)), want);
                end
            end
        end
    endtask

    task automatic test_memory();
        lc3b_word v1;
        lc3b_word v2;
        v1 = 16'($random(seed)) | 16'h0080;        // negative low byte
        v2 = 16'($random(seed)) & 16'hff7f;
        hold_reset();
        clear_memories();
        write_word(0, v1);
        write_word(2, v2);
        emit(encode(op_ldr, 3'd1, 3'd0, 6'd0));
        emit(encode(op_ldr, 3'd2, 3'd0, 6'd1));
        emit(encode(op_stb, 3'd1, 3'd0, 6'd17));     // odd lane
        emit(encode(op_stb, 3'd2, 3'd0, 6'd18));     // even lane
        emit(encode(op_ldb, 3'd3, 3'd0, 6'd17));
        emit(encode(op_str, 3'd3, 3'd0, 6'd12));
        emit(encode(op_ldb, 3'd4, 3'd0, 6'd18));
        emit(encode(op_str, 3'd4, 3'd0, 6'd13));
        emit(encode(op_add, 3'd5, 3'd0, {1'b1, 5'd1}));
        emit(encode(op_str, 3'd2, 3'd5, 6'd10));     // byte 21 aligns to 20
        emit(encode(op_ldr, 3'd6, 3'd5, 6'd0));      // byte 1 aligns to 0
        emit(encode(op_str, 3'd6, 3'd0, 6'd14));
        emit(HALT);
        release_reset();
        run_to_halt();
        compare("byte 16 untouched", {8'h00, dmem[16]}, {8'h00, fill_byte(10'd16)});
        compare("stb odd", {8'h00, dmem[17]}, {8'h00, v1[7:0]});
        compare("stb even", {8'h00, dmem[18]}, {8'h00, v2[7:0]});
        compare("byte 19 untouched", {8'h00, dmem[19]}, {8'h00, fill_byte(10'd19)});
        compare("ldb odd", read_word(24), {{8{v1[7]}}, v1[7:0]});
        compare("ldb even", read_word(26), {{8{v2[7]}}, v2[7:0]});
        compare("str odd address", read_word(20), v2);
        compare("ldr odd address", read_word(28), v1);
    endtask

    task automatic test_branch();
        logic [4:0] imms [3];
        lc3b_nzp    cc;
        imms = '{5'(-3), 5'd0, 5'd5};
        for (int kind = 0; kind < 4; kind++) begin
            for (int m = 0; m < 8; m++) begin
                hold_reset();
                clear_memories();
                if (kind < 3) begin
                    emit(encode(op_add, 3'd1, 3'd0, {1'b1, imms[kind]}));
                    cc = nzp_of({{11{imms[kind][4]}}, imms[kind]});
                end else begin
                    emit({op_rti, 12'h000});       // cc stays at its reset value
                    cc = `LC3B_CC_RESET;
                end
                emit(encode9(op_br, 3'(m), 9'd4)); // at 2 with target 4 + 8
                emit(HALT);
                place(12);
                emit(HALT);
                release_reset();
                run_to_halt();
                compare("branch", inst_addr, (|(3'(m) & cc)) ? 16'd12 : 16'd4);
            end
        end
    endtask

    task automatic test_lea();
        int       offs [3];
        lc3b_word addr;
        offs = '{-8, -1, 3};
        for (int j = 0; j < 3; j++) begin
            for (int m = 0; m < 3; m++) begin
                addr = 16'd2 + 16'(offs[j] * 2);
                hold_reset();
                clear_memories();
                emit(encode9(op_lea, 3'd2, 9'(offs[j])));
                emit(encode(op_str, 3'd2, 3'd0, 6'd16));
                emit(encode9(op_br, 3'b100 >> m, 9'd3));     // at 4 with target 6 + 6
                emit(HALT);
                place(12);
                emit(HALT);
                release_reset();
                run_to_halt();
                compare("lea address", read_word(32), addr);
                compare("branch after lea", inst_addr,
                        (|((3'b100 >> m) & nzp_of(addr))) ? 16'd12 : 16'd6);
            end
        end
    endtask

    task automatic test_jumps();
        lc3b_word jsr_link;
        lc3b_word jsr_target;
        jsr_link = 16'd12 + 16'd2;
        jsr_target = jsr_link + 16'd8;
        hold_reset();
        clear_memories();
        emit(encode(op_add, 3'd1, 3'd0, {1'b1, 5'd12}));
        emit(encode(op_jmp, 3'd0, 3'd1, 6'd0));
        emit(HALT);                                   // wrong path
        place(12);
        emit({op_jsr, 1'b1, 11'd4});
        emit(HALT);
        place(int'(jsr_target));
        emit(encode(op_str, 3'd7, 3'd0, 6'd16));
        emit(encode(op_add, 3'd2, 3'd0, {1'b1, 5'd15}));
        emit(encode(op_add, 3'd2, 3'd2, {1'b1, 5'd15}));
        emit(encode(op_add, 3'd2, 3'd2, {1'b1, 5'd10}));   // r2 = 40
        emit(encode(op_jsr, 3'd0, 3'd2, 6'd0));             // jsrr at 30
        emit(HALT);
        place(40);
        emit(encode(op_str, 3'd7, 3'd0, 6'd17));
        emit(encode(op_add, 3'd7, 3'd0, {1'b1, 5'd14}));
        emit(encode(op_add, 3'd7, 3'd7, 6'd7));
        emit(encode(op_add, 3'd7, 3'd7, 6'd7));             // r7 = 56
        emit(encode(op_jmp, 3'd0, 3'd7, 6'd0));             // ret
        emit(HALT);
        place(56);
        emit(HALT);
        release_reset();
        run_to_halt();
        compare("jmp target", pc_trace[2], 16'd12);
        compare("jsr target", pc_trace[3], jsr_target);
        compare("jsrr target", pc_trace[8], 16'd40);
        compare("ret target", inst_addr, 16'd56);
        compare("jsr link", read_word(32), jsr_link);
        compare("jsrr link", read_word(34), 16'd30 + 16'd2);
    endtask

    task automatic test_noop();
        hold_reset();
        clear_memories();
        emit(encode(op_add, 3'd1, 3'd0, {1'b1, 5'(-5)}));    // cc negative
        emit({op_ldi, 3'd1, 9'($random(seed))});
        emit({op_sti, 3'd1, 9'($random(seed))});
        emit({op_trap, 4'h0, 8'($random(seed))});
        emit({op_rti, 12'h000});
        emit(encode(op_str, 3'd1, 3'd0, 6'd16));
        emit(encode9(op_br, 3'b100, 9'd1));                   // at 12 with target 16
        emit(HALT);
        emit(HALT);
        release_reset();
        run_to_halt();
        compare("register after no-ops", read_word(32), 16'hfffb);
        compare("cc after no-ops", inst_addr, 16'd16);
        compare("word at 0 untouched", read_word(0), {fill_byte(10'd1), fill_byte(10'd0)});
    endtask

    initial begin
        seed = 32'h40ca_9c0b;
        clk = 1'b0;
        reset = 1'b1;
        checks = 0;
        errors = 0;
        clear_memories();
        test_alu();
        test_shift();
        test_memory();
        test_branch();
        test_lea();
        test_jumps();
        test_noop();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule : lc3b_core_tb

//--- sources.f
+incdir+include
source/lc3b_types.sv
source/lc3b_control_types.sv
source/control_rom.sv
source/regfile.sv
source/execute_unit.sv
source/result_unit.sv
source/lc3b_core.sv
tests/lc3b_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lc3b_core_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
